// ==== all.f ====
rx_buffer_pkg.sv
rx_buffer_ram.sv
rx_buffer_ctrl.sv
rx_buffer_align.sv
rx_buffer.sv
tb_clock.sv
tb_rx_buffer.sv

// ==== Makefile ====
# Verilator build and run for the receive packet buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_buffer
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_rx_buffer.sv ====
// Testbench for the receive packet buffer
// Fills packets through a show-ahead FIFO model and checks access port reads
// against a reference byte array

`timescale 1ns/100ps
`default_nettype none

module tb_rx_buffer;

  localparam int ADDR_WIDTH = 10;
  localparam int REF_BYTES  = 128;
  // About 60 reads of up to 6 cycles, two fills and reset come to roughly 400
  localparam int MAX_CYCLES = 4000;

  logic                      clk;
  logic                      areset;
  logic                      packet_available;
  logic                      fifo_empty;
  logic [63:0]               fifo_data;
  logic                      rd_en;
  logic [ADDR_WIDTH+2:0]     rd_addr;
  rx_buffer_pkg::word_size_t rd_size;
  logic                      fifo_rd_en;
  logic                      port_wait;
  logic                      rd_dv;
  logic [63:0]               rd_data;

  logic [63:0] fifo_q [$];
  logic [7:0]  ref_bytes [0:REF_BYTES-1];
  logic        pop_req = 1'b0;
  int          pop_count = 0;
  int          cycle_count = 0;
  integer      seed;

  tb_clock #(
    .PERIOD_NS    (8.0),
    .RESET_CYCLES (16)
  ) clock_i (
    .o_clk    (clk),
    .o_areset (areset)
  );

  rx_buffer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) rx_buffer_i (
    .i_clk                       (clk),
    .i_areset                    (areset),
    .i_dispatch_packet_available (packet_available),
    .i_dispatch_fifo_empty       (fifo_empty),
    .i_dispatch_fifo_rd_data     (fifo_data),
    .i_access_port_rd_en         (rd_en),
    .i_access_port_addr          (rd_addr),
    .i_access_port_wordsize      (rd_size),
    .o_dispatch_fifo_rd_en       (fifo_rd_en),
    .o_access_port_wait          (port_wait),
    .o_access_port_rd_dv         (rd_dv),
    .o_access_port_rd_data       (rd_data)
  );

  // FIFO model consumes a word on each edge that saw the read enable
  always @(posedge clk) begin
    pop_req <= fifo_rd_en;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Advance to the next falling edge and present the FIFO head
  task automatic step();
    @(negedge clk);
    if (pop_req) begin
      assert (fifo_q.size() != 0)
        else abort_run($sformatf("Fail %0t: FIFO read enable while the FIFO was empty",
                                 $time));
      void'(fifo_q.pop_front());
      pop_count++;
    end
    fifo_empty = (fifo_q.size() == 0);
    fifo_data  = fifo_empty ? 64'd0 : fifo_q[0];
  endtask

  // Bytes addr to addr+n-1, first byte most significant
  function automatic logic [63:0] expected_read(input int addr, input int n_bytes);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < n_bytes; i++) begin
      value = {value[55:0], ref_bytes[addr + i]};
    end
    return value;
  endfunction

  task automatic fill_packet(input int n_words, input bit read_pulse);
    logic [63:0] word;
    int          start_pops;
    for (int w = 0; w < n_words; w++) begin
      word = {$random(seed), $random(seed)};
      fifo_q.push_back(word);
      for (int k = 0; k < 8; k++) begin
        ref_bytes[w*8 + k] = word[63-8*k -: 8];
      end
    end
    start_pops = pop_count;
    step();
    packet_available = 1'b1;
    // A read in this cycle loses against the pending packet
    rd_en   = read_pulse;
    rd_addr = '0;
    rd_size = rx_buffer_pkg::size_64;
    while (fifo_q.size() != 0) begin
      step();
      rd_en = 1'b0;
      assert (!rd_dv && !port_wait)
        else abort_run($sformatf("Fail %0t: read served during a packet fill", $time));
    end
    packet_available = 1'b0;
    repeat (4) begin
      step();
      assert (!pop_req && !rd_dv)
        else abort_run($sformatf("Fail %0t: FIFO read or data valid after the fill ended",
                                 $time));
    end
    assert (pop_count - start_pops == n_words)
      else abort_run($sformatf("Fail %0t: %0d FIFO reads for a %0d word packet",
                               $time, pop_count - start_pops, n_words));
  endtask

  task automatic check_read(input int addr, input rx_buffer_pkg::word_size_t size);
    int          n_bytes;
    int          exp_edges;
    int          edges;
    logic [63:0] expected;
    n_bytes   = 1 << int'(size);
    exp_edges = ((addr % 8) + n_bytes > 8) ? 3 : 2;
    expected  = expected_read(addr, n_bytes);
    step();
    rd_en   = 1'b1;
    rd_addr = addr[ADDR_WIDTH+2:0];
    rd_size = size;
    step();
    rd_en = 1'b0;
    edges = 0;
    while (!rd_dv && edges < 8) begin
      assert (port_wait)
        else abort_run($sformatf("Fail %0t: wait low during read at byte %0d", $time, addr));
      step();
      edges++;
    end
    assert (rd_dv)
      else abort_run($sformatf("Fail %0t: no data valid for the read at byte %0d",
                               $time, addr));
    assert (edges == exp_edges && !port_wait)
      else abort_run($sformatf("Fail %0t: read at byte %0d done after %0d edges, expected %0d",
                               $time, addr, edges, exp_edges));
    assert (rd_data == expected)
      else abort_run($sformatf("Fail %0t: %0d-bit read at byte %0d gave %h, expected %h",
                               $time, n_bytes * 8, addr, rd_data, expected));
    step();
    assert (!rd_dv && !port_wait && rd_data == expected)
      else abort_run($sformatf("Fail %0t: data valid or data not held after read at byte %0d",
                               $time, addr));
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  // All outputs low once reset is released
  task automatic check_reset_state();
    step();
    assert (!fifo_rd_en && !port_wait && !rd_dv && rd_data == '0)
      else abort_run($sformatf("Fail %0t: outputs not low after reset", $time));
  endtask

  task automatic fill_and_read_words();
    fill_packet(16, 1'b0);
    for (int w = 0; w < 16; w++) begin
      check_read(w * 8, rx_buffer_pkg::size_64);
    end
  endtask

  task automatic read_bytes_at_offsets();
    for (int off = 0; off < 8; off++) begin
      check_read(24 + off, rx_buffer_pkg::size_8);
    end
  endtask

  // Offsets 7 for 16 bits and 5 to 7 for 32 bits cross into the next word
  task automatic read_short_at_offsets();
    for (int off = 0; off < 8; off++) begin
      check_read(40 + off, rx_buffer_pkg::size_16);
      check_read(40 + off, rx_buffer_pkg::size_32);
    end
  endtask

  task automatic read_wide_unaligned();
    for (int off = 1; off < 8; off++) begin
      check_read(64 + off, rx_buffer_pkg::size_64);
    end
  endtask

  // Shorter packet written over the old one
  // Words 5 and up keep their contents
  task automatic refill_shorter_packet();
    fill_packet(5, 1'b1);
    for (int w = 0; w < 8; w++) begin
      check_read(w * 8, rx_buffer_pkg::size_64);
    end
    check_read(4 * 8 + 3, rx_buffer_pkg::size_64);
  endtask

  initial begin
    seed             = 32'h979b_1b2f;
    packet_available = 1'b0;
    fifo_empty       = 1'b1;
    fifo_data        = '0;
    rd_en            = 1'b0;
    rd_addr          = '0;
    rd_size          = rx_buffer_pkg::size_8;
    wait (areset === 1'b0);
    check_reset_state();
    fill_and_read_words();
    read_bytes_at_offsets();
    read_short_at_offsets();
    read_wide_unaligned();
    refill_shorter_packet();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Testbench clock and reset
// Free-running clock and an active-high reset held for a set number of cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_areset
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end
  end

  // Release away from the rising edge
  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_areset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== rx_buffer.sv ====
// Receive packet buffer
// Stores a packet from the dispatch FIFO and serves unaligned reads of
// 8 to 64 bits through the access port

`timescale 1ns/100ps
`default_nettype none

module rx_buffer #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire                                                 i_clk,
  input  wire                                                 i_areset,
  input  wire                                                 i_dispatch_packet_available,
  input  wire                                                 i_dispatch_fifo_empty,
  input  wire  [rx_buffer_pkg::word_width-1:0]                i_dispatch_fifo_rd_data,
  input  wire                                                 i_access_port_rd_en,
  input  wire  [ADDR_WIDTH+rx_buffer_pkg::byte_sel_width-1:0] i_access_port_addr,
  input  wire  rx_buffer_pkg::word_size_t                     i_access_port_wordsize,
  output logic                                                o_dispatch_fifo_rd_en,
  output logic                                                o_access_port_wait,
  output logic                                                o_access_port_rd_dv,
  output logic [rx_buffer_pkg::word_width-1:0]                o_access_port_rd_data
);

  logic [ADDR_WIDTH-1:0]                    ram_addr;
  logic                                     ram_wr_en;
  logic [rx_buffer_pkg::word_width-1:0]     ram_wr_data;
  logic [rx_buffer_pkg::word_width-1:0]     ram_rd_data;
  logic                                     load_first;
  logic                                     load_second;
  logic                                     read_last;
  rx_buffer_pkg::word_size_t                read_size;
  logic [rx_buffer_pkg::byte_sel_width-1:0] read_offset;

  rx_buffer_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ctrl_i (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .i_access_port_rd_en         (i_access_port_rd_en),
    .i_access_port_addr          (i_access_port_addr),
    .i_access_port_wordsize      (i_access_port_wordsize),
    .o_dispatch_fifo_rd_en       (o_dispatch_fifo_rd_en),
    .o_access_port_wait          (o_access_port_wait),
    .o_ram_addr                  (ram_addr),
    .o_ram_wr_en                 (ram_wr_en),
    .o_ram_wr_data               (ram_wr_data),
    .o_load_first                (load_first),
    .o_load_second               (load_second),
    .o_read_last                 (read_last),
    .o_read_size                 (read_size),
    .o_read_offset               (read_offset)
  );

  rx_buffer_ram #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_i (
    .i_clk     (i_clk),
    .i_addr    (ram_addr),
    .i_wr_en   (ram_wr_en),
    .i_wr_data (ram_wr_data),
    .o_rd_data (ram_rd_data)
  );

  rx_buffer_align align_i (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_ram_rd_data         (ram_rd_data),
    .i_load_first          (load_first),
    .i_load_second         (load_second),
    .i_read_last           (read_last),
    .i_read_size           (read_size),
    .i_read_offset         (read_offset),
    .o_access_port_rd_dv   (o_access_port_rd_dv),
    .o_access_port_rd_data (o_access_port_rd_data)
  );

endmodule

`default_nettype wire

// ==== rx_buffer_align.sv ====
// Receive buffer read aligner
// Picks the requested bytes out of one or two RAM words, right-justifies
// them and pulses data valid when the read completes

`timescale 1ns/100ps
`default_nettype none

module rx_buffer_align (
  input  wire                                      i_clk,
  input  wire                                      i_areset,
  input  wire  [rx_buffer_pkg::word_width-1:0]     i_ram_rd_data,
  input  wire                                      i_load_first,
  input  wire                                      i_load_second,
  input  wire                                      i_read_last,
  input  wire  rx_buffer_pkg::word_size_t          i_read_size,
  input  wire  [rx_buffer_pkg::byte_sel_width-1:0] i_read_offset,
  output logic                                     o_access_port_rd_dv,
  output logic [rx_buffer_pkg::word_width-1:0]     o_access_port_rd_data
);

  logic [3:0]                              n_bytes;
  logic [rx_buffer_pkg::word_width-1:0]    size_mask;
  logic [3:0]                              read_end;
  logic [3:0]                              tail_bytes;
  logic [6:0]                              shift_bits;
  logic [2*rx_buffer_pkg::word_width-1:0]  first_window;
  logic [rx_buffer_pkg::word_width-1:0]    first_part;
  logic [rx_buffer_pkg::word_width-1:0]    second_part;
  logic [rx_buffer_pkg::word_width-1:0]    partial;

  // --------------------------------------------------
  // Byte extraction
  // --------------------------------------------------

  always_comb begin
    case (i_read_size)
      rx_buffer_pkg::size_8: begin
        n_bytes   = 4'd1;
        size_mask = 64'h0000_0000_0000_00ff;
      end
      rx_buffer_pkg::size_16: begin
        n_bytes   = 4'd2;
        size_mask = 64'h0000_0000_0000_ffff;
      end
      rx_buffer_pkg::size_32: begin
        n_bytes   = 4'd4;
        size_mask = 64'h0000_0000_ffff_ffff;
      end
      default: begin
        n_bytes   = 4'd8;
        size_mask = '1;
      end
    endcase
  end

  // Requested bytes end at read_end inside a two-word window
  // The distance to the window end sets the right shift
  assign read_end   = {1'b0, i_read_offset} + n_bytes;
  assign tail_bytes = 4'd0 - read_end;
  assign shift_bits = {tail_bytes, 3'b000};

  // First word in the upper half. Bytes past the word end arrive later
  assign first_window = {i_ram_rd_data, {rx_buffer_pkg::word_width{1'b0}}} >> shift_bits;
  assign first_part   = first_window[rx_buffer_pkg::word_width-1:0] & size_mask;

  // Leading bytes of the next word fill the low end
  assign second_part = i_ram_rd_data >> shift_bits;

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_load_first) begin
      partial <= first_part;
    end
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_access_port_rd_dv   <= 1'b0;
      o_access_port_rd_data <= '0;
    end else begin
      o_access_port_rd_dv <= (i_load_first && i_read_last) || i_load_second;
      if (i_load_first && i_read_last) begin
        o_access_port_rd_data <= first_part;
      end else if (i_load_second) begin
        o_access_port_rd_data <= partial | second_part;
      end
    end
  end

  a_single_load: assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_load_first && i_load_second))
    else $error("first and second load together");

endmodule

`default_nettype wire

// ==== rx_buffer_ctrl.sv ====
// Receive buffer controller
// Arbitrates packet fill against access port reads, sequences the RAM
// and raises the load strobes for the aligner

`timescale 1ns/100ps
`default_nettype none

module rx_buffer_ctrl #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire                                                  i_clk,
  input  wire                                                  i_areset,
  input  wire                                                  i_dispatch_packet_available,
  input  wire                                                  i_dispatch_fifo_empty,
  input  wire  [rx_buffer_pkg::word_width-1:0]                 i_dispatch_fifo_rd_data,
  input  wire                                                  i_access_port_rd_en,
  input  wire  [ADDR_WIDTH+rx_buffer_pkg::byte_sel_width-1:0]  i_access_port_addr,
  input  wire  rx_buffer_pkg::word_size_t                      i_access_port_wordsize,
  output logic                                                 o_dispatch_fifo_rd_en,
  output logic                                                 o_access_port_wait,
  output logic [ADDR_WIDTH-1:0]                                o_ram_addr,
  output logic                                                 o_ram_wr_en,
  output logic [rx_buffer_pkg::word_width-1:0]                 o_ram_wr_data,
  output logic                                                 o_load_first,
  output logic                                                 o_load_second,
  output logic                                                 o_read_last,
  output rx_buffer_pkg::word_size_t                            o_read_size,
  output logic [rx_buffer_pkg::byte_sel_width-1:0]             o_read_offset
);

  rx_buffer_pkg::ctrl_state_t state;
  rx_buffer_pkg::ctrl_state_t state_next;

  logic [ADDR_WIDTH-1:0]                    fill_addr;
  logic [ADDR_WIDTH-1:0]                    word_addr;
  logic [rx_buffer_pkg::byte_sel_width-1:0] req_offset;
  logic [3:0]                               req_end;
  logic                                     size_legal;
  logic                                     crossing;
  logic                                     fill_ready;
  logic                                     rd_accept;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------

  assign fill_ready = i_dispatch_packet_available && !i_dispatch_fifo_empty;
  assign req_offset = i_access_port_addr[rx_buffer_pkg::byte_sel_width-1:0];

  // End byte of the request, counted from the start of the first word
  always_comb begin
    size_legal = 1'b1;
    case (i_access_port_wordsize)
      rx_buffer_pkg::size_8:  req_end = {1'b0, req_offset} + 4'd1;
      rx_buffer_pkg::size_16: req_end = {1'b0, req_offset} + 4'd2;
      rx_buffer_pkg::size_32: req_end = {1'b0, req_offset} + 4'd4;
      rx_buffer_pkg::size_64: req_end = {1'b0, req_offset} + 4'd8;
      default: begin
        req_end    = 4'd0;
        size_legal = 1'b0;
      end
    endcase
  end

  assign crossing = req_end > 4'd8;

  // A fillable packet wins, so a read pulse in that cycle is lost
  assign rd_accept = (state == rx_buffer_pkg::idle) && !fill_ready &&
                     i_access_port_rd_en && size_legal;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      rx_buffer_pkg::idle: begin
        if (fill_ready) begin
          state_next = rx_buffer_pkg::fill;
        end else if (rd_accept) begin
          state_next = crossing ? rx_buffer_pkg::read_next_addr : rx_buffer_pkg::read_addr;
        end
      end
      rx_buffer_pkg::fill: begin
        if (i_dispatch_fifo_empty) begin
          state_next = rx_buffer_pkg::idle;
        end
      end
      rx_buffer_pkg::read_addr:      state_next = rx_buffer_pkg::read_word;
      rx_buffer_pkg::read_next_addr: state_next = rx_buffer_pkg::read_first;
      rx_buffer_pkg::read_first:     state_next = rx_buffer_pkg::read_second;
      default:                       state_next = rx_buffer_pkg::idle;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state         <= rx_buffer_pkg::idle;
      fill_addr     <= '0;
      word_addr     <= '0;
      o_read_size   <= rx_buffer_pkg::size_8;
      o_read_offset <= '0;
      o_read_last   <= 1'b0;
    end else begin
      state <= state_next;

      // Every packet lands at word 0
      if (state == rx_buffer_pkg::idle) begin
        fill_addr <= '0;
      end else if (o_dispatch_fifo_rd_en) begin
        fill_addr <= fill_addr + 1'b1;
      end

      if (rd_accept) begin
        word_addr     <= i_access_port_addr[ADDR_WIDTH+rx_buffer_pkg::byte_sel_width-1:
                                            rx_buffer_pkg::byte_sel_width];
        o_read_size   <= i_access_port_wordsize;
        o_read_offset <= req_offset;
        o_read_last   <= !crossing;
      end else if (state == rx_buffer_pkg::read_next_addr) begin
        // Step on to the second word while the first is read
        word_addr <= word_addr + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------

  assign o_dispatch_fifo_rd_en = (state == rx_buffer_pkg::fill) && !i_dispatch_fifo_empty;
  assign o_ram_wr_en           = o_dispatch_fifo_rd_en;
  assign o_ram_wr_data         = i_dispatch_fifo_rd_data;
  assign o_ram_addr            = (state == rx_buffer_pkg::fill) ? fill_addr : word_addr;

  assign o_access_port_wait = (state != rx_buffer_pkg::idle) && (state != rx_buffer_pkg::fill);
  assign o_load_first       = (state == rx_buffer_pkg::read_word) ||
                              (state == rx_buffer_pkg::read_first);
  assign o_load_second      = (state == rx_buffer_pkg::read_second);

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------

  a_state_legal: assert property (@(posedge i_clk) disable iff (i_areset)
    state inside {rx_buffer_pkg::idle, rx_buffer_pkg::fill, rx_buffer_pkg::read_addr,
                  rx_buffer_pkg::read_word, rx_buffer_pkg::read_next_addr,
                  rx_buffer_pkg::read_first, rx_buffer_pkg::read_second})
    else $error("controller state out of range");

  // Second load must come right after the first load of a crossing read
  a_second_after_first: assert property (@(posedge i_clk) disable iff (i_areset)
    o_load_second |-> $past(o_load_first && !o_read_last))
    else $error("second load without a crossing first load");

endmodule

`default_nettype wire

// ==== rx_buffer_ram.sv ====
// Receive buffer RAM
// Single port, registered read data with one cycle of latency

`timescale 1ns/100ps
`default_nettype none

module rx_buffer_ram #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire                                  i_clk,
  input  wire  [ADDR_WIDTH-1:0]                i_addr,
  input  wire                                  i_wr_en,
  input  wire  [rx_buffer_pkg::word_width-1:0] i_wr_data,
  output logic [rx_buffer_pkg::word_width-1:0] o_rd_data
);

  logic [rx_buffer_pkg::word_width-1:0] mem [0:2**ADDR_WIDTH-1];

  // Read returns the old contents when the same address is written
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_addr];
  end

endmodule

`default_nettype wire

// ==== rx_buffer_pkg.sv ====
// Receive buffer shared definitions
// Word and byte-select widths, access size encoding and controller states

`default_nettype none

package rx_buffer_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // One RAM word and one access port read
  localparam int word_width = 64;

  // Byte offset inside a RAM word
  localparam int byte_sel_width = 3;

  // --------------------------------------------------
  // Access size encoding
  // --------------------------------------------------

  // Codes 4 to 7 are not defined and are ignored by the controller
  typedef enum logic [2:0] {
    size_8  = 3'd0,
    size_16 = 3'd1,
    size_32 = 3'd2,
    size_64 = 3'd3
  } word_size_t;

  // --------------------------------------------------
  // Controller states
  // --------------------------------------------------

  typedef enum logic [2:0] {
    idle,
    fill,
    read_addr,
    read_word,
    read_next_addr,
    read_first,
    read_second
  } ctrl_state_t;

endpackage

`default_nettype wire
